//--- hdl/ocl_cfg_pkg.sv
package ocl_cfg_pkg;

   // --------------------------------------------------
   // Widths
   // --------------------------------------------------
   typedef logic [31:0] axil_addr_t;   // Byte address
   typedef logic [31:0] axil_data_t;
   typedef logic [3:0]  axil_strb_t;
   typedef logic [1:0]  axil_resp_t;
   typedef logic [16:0] tst_sel_t;     // Slot number, addr bits 24:8

   // Configuration bus, slave to target
   typedef struct packed {
      axil_addr_t addr;
      axil_data_t wdata;
      logic       wr;    // One-cycle write strobe
      logic       rd;    // One-cycle read strobe
   } cfg_req_t;

   // Configuration bus, target to slave
   typedef struct packed {
      logic       ack;   // Pulse, rdata valid with it
      axil_data_t rdata;
   } cfg_rsp_t;

   // --------------------------------------------------
   // AXI-Lite
   // --------------------------------------------------
   typedef struct packed {
      axil_addr_t awaddr;
      logic       awvalid;
      axil_data_t wdata;
      axil_strb_t wstrb;
      logic       wvalid;
      logic       bready;
      axil_addr_t araddr;
      logic       arvalid;
      logic       rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      axil_resp_t bresp;
      logic       arready;
      logic       rvalid;
      axil_data_t rdata;
      axil_resp_t rresp;
   } axil_rsp_t;

   typedef enum logic [2:0] {
      SLV_IDLE    = 3'd0,
      SLV_WR_ADDR = 3'd1,
      SLV_CYC     = 3'd2,
      SLV_RESP    = 3'd3
   } slv_state_t;

   localparam axil_data_t UNMAPPED_RDATA = 32'hdead_beef;   // Reads of empty slots

endpackage

//--- hdl/axil_in_fifo.sv
`timescale 1ns/1ps

module axil_in_fifo #(
   parameter int FIFO_DEPTH = 3
) (
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  ocl_cfg_pkg::axil_req_t host_req,
   output ocl_cfg_pkg::axil_rsp_t host_rsp,
   output ocl_cfg_pkg::axil_req_t slv_req,
   input  ocl_cfg_pkg::axil_rsp_t slv_rsp
);

   import ocl_cfg_pkg::*;

   localparam int NUM_CH = 3;
   localparam int CH_AW  = 0;
   localparam int CH_W   = 1;
   localparam int CH_AR  = 2;
   localparam int ADDR_W = $bits(axil_addr_t);
   localparam int DATA_W = $bits(axil_data_t);
   localparam int PAY_W  = DATA_W + $bits(axil_strb_t);   // Widest entry is W
   localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

   logic [PAY_W-1:0] mem [NUM_CH][FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr [NUM_CH];
   logic [PTR_W-1:0] rd_ptr [NUM_CH];
   logic [CNT_W-1:0] cnt [NUM_CH];
   logic [CNT_W-1:0] cnt_nxt [NUM_CH];
   logic [PAY_W-1:0] in_pay [NUM_CH];
   logic [PAY_W-1:0] out_pay [NUM_CH];
   logic [NUM_CH-1:0] in_vld, out_vld, out_rdy;
   logic [NUM_CH-1:0] host_rdy;                      // Registered, from stored count only
   logic [NUM_CH-1:0] push, pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // Channel mapping
   always_comb
   begin
      in_vld[CH_AW]  = host_req.awvalid;
      in_vld[CH_W]   = host_req.wvalid;
      in_vld[CH_AR]  = host_req.arvalid;
      in_pay[CH_AW]  = PAY_W'(host_req.awaddr);
      in_pay[CH_W]   = {host_req.wstrb, host_req.wdata};
      in_pay[CH_AR]  = PAY_W'(host_req.araddr);
      out_rdy[CH_AW] = slv_rsp.awready;
      out_rdy[CH_W]  = slv_rsp.wready;
      out_rdy[CH_AR] = slv_rsp.arready;
      for (int c = 0; c < NUM_CH; c++)
      begin
         out_vld[c] = (cnt[c] != '0);
         out_pay[c] = mem[c][rd_ptr[c]];           // Head entry
         push[c]    = in_vld[c] & host_rdy[c];
         pop[c]     = out_vld[c] & out_rdy[c];
         cnt_nxt[c] = cnt[c] + CNT_W'(push[c]) - CNT_W'(pop[c]);
      end
   end

   // --------------------------------------------------
   // Pointers and counts
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         wr_ptr   <= '{default: '0};
         rd_ptr   <= '{default: '0};
         cnt      <= '{default: '0};
         host_rdy <= '0;
      end
      else
      begin
         for (int c = 0; c < NUM_CH; c++)
         begin
            if (push[c])
               wr_ptr[c] <= ptr_inc(wr_ptr[c]);
            if (pop[c])
               rd_ptr[c] <= ptr_inc(rd_ptr[c]);
            cnt[c]      <= cnt_nxt[c];
            host_rdy[c] <= (cnt_nxt[c] < CNT_W'(FIFO_DEPTH));   // Room left
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int c = 0; c < NUM_CH; c++)
         if (push[c])
            mem[c][wr_ptr[c]] <= in_pay[c];
   end

   // Slave side sees the heads, responses pass straight back
   always_comb
   begin
      slv_req         = host_req;                  // bready, rready
      slv_req.awvalid = out_vld[CH_AW];
      slv_req.awaddr  = out_pay[CH_AW][ADDR_W-1:0];
      slv_req.wvalid  = out_vld[CH_W];
      slv_req.wdata   = out_pay[CH_W][DATA_W-1:0];
      slv_req.wstrb   = out_pay[CH_W][PAY_W-1:DATA_W];
      slv_req.arvalid = out_vld[CH_AR];
      slv_req.araddr  = out_pay[CH_AR][ADDR_W-1:0];

      host_rsp         = slv_rsp;                  // B and R channels
      host_rsp.awready = host_rdy[CH_AW];
      host_rsp.wready  = host_rdy[CH_W];
      host_rsp.arready = host_rdy[CH_AR];
   end

endmodule

//--- hdl/tst_cfg_regs.sv
`timescale 1ns/1ps

module tst_cfg_regs #(
   parameter int ACK_DLY = 2
) (
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  ocl_cfg_pkg::cfg_req_t cfg_req,
   output ocl_cfg_pkg::cfg_rsp_t cfg_rsp
);

   import ocl_cfg_pkg::*;

   localparam int CNT_W = $clog2(ACK_DLY + 1);

   logic [1:0]       reg_idx;
   axil_data_t       regs [4];
   axil_data_t       rdata_q;
   logic [CNT_W-1:0] ack_cnt;   // Counts down to the ack

   assign reg_idx = cfg_req.addr[3:2];   // Other offset bits alias

   // --------------------------------------------------
   // Register file
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         regs <= '{default: '0};
      else if (cfg_req.wr)
         regs[reg_idx] <= cfg_req.wdata;
   end

   always_ff @(posedge clk)
   begin
      if (cfg_req.rd)
         rdata_q <= regs[reg_idx];
   end

   // Ack delay
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         ack_cnt <= '0;
      else if (cfg_req.wr || cfg_req.rd)
         ack_cnt <= CNT_W'(ACK_DLY);
      else if (ack_cnt != '0)
         ack_cnt <= ack_cnt - 1'b1;
   end

   assign cfg_rsp.ack   = (ack_cnt == CNT_W'(1));   // ACK_DLY cycles after strobe
   assign cfg_rsp.rdata = rdata_q;

endmodule

//--- hdl/ocl_cfg_slv.sv
`timescale 1ns/1ps

module ocl_cfg_slv #(
   parameter int NUM_TST = 6
) (
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  ocl_cfg_pkg::axil_req_t axil_req,
   output ocl_cfg_pkg::axil_rsp_t axil_rsp,
   output ocl_cfg_pkg::cfg_req_t  cfg_req [NUM_TST],
   input  ocl_cfg_pkg::cfg_rsp_t  cfg_rsp [NUM_TST]
);

   import ocl_cfg_pkg::*;

   slv_state_t slv_state, slv_state_nxt;

   logic         slv_cyc_wr;        // Latched winner, write when set
   axil_addr_t   slv_wr_addr;
   axil_addr_t   slv_rd_addr;
   axil_addr_t   slv_mx_addr;
   tst_sel_t     slv_sel;
   logic         slv_slot_hit;      // Slot has a target behind it
   logic         slv_mx_req_valid;
   logic         slv_mx_rsp_ready;
   logic         slv_did_req;       // One strobe per access
   logic         slv_cyc_go;
   logic         slv_cyc_done;
   logic         sel_ack;
   axil_data_t   sel_rdata;
   axil_data_t   slv_rdata;
   axil_addr_t   cfg_addr_q;
   axil_data_t   cfg_wdata_q;
   logic [NUM_TST-1:0] tst_wr, tst_rd;
   logic         aw_rdy_q, w_rdy_q, ar_rdy_q;

   assign slv_mx_req_valid = slv_cyc_wr ? axil_req.wvalid : 1'b1;   // Write waits for W
   assign slv_mx_rsp_ready = slv_cyc_wr ? axil_req.bready : axil_req.rready;

   // Both heads captured in IDLE, winner picks one
   always_ff @(posedge clk)
   begin
      if ((slv_state == SLV_IDLE) && (axil_req.awvalid || axil_req.arvalid))
      begin
         slv_wr_addr <= axil_req.awaddr;
         slv_rd_addr <= axil_req.araddr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         slv_cyc_wr <= 1'b0;
      else if (slv_state == SLV_IDLE)
         slv_cyc_wr <= axil_req.awvalid;   // Writes first
   end

   assign slv_mx_addr  = slv_cyc_wr ? slv_wr_addr : slv_rd_addr;
   assign slv_sel      = slv_mx_addr[24:8];   // 256B slots
   assign slv_slot_hit = (slv_sel < tst_sel_t'(NUM_TST));

   // Ack and data of the selected target
   always_comb
   begin
      sel_ack   = 1'b0;
      sel_rdata = UNMAPPED_RDATA;
      for (int i = 0; i < NUM_TST; i++)
      begin
         if (slv_sel == tst_sel_t'(i))
         begin
            sel_ack   = cfg_rsp[i].ack;
            sel_rdata = cfg_rsp[i].rdata;
         end
      end
   end

   assign slv_cyc_done = slv_slot_hit ? sel_ack : slv_mx_req_valid;

   // --------------------------------------------------
   // State machine
   // --------------------------------------------------
   always_comb
   begin
      slv_state_nxt = slv_state;
      case (slv_state)
         SLV_IDLE:
         begin
            if (axil_req.awvalid)
               slv_state_nxt = SLV_WR_ADDR;
            else if (axil_req.arvalid)
               slv_state_nxt = SLV_CYC;
         end
         SLV_WR_ADDR: slv_state_nxt = SLV_CYC;
         SLV_CYC:
         begin
            if (slv_cyc_done)
               slv_state_nxt = SLV_RESP;
         end
         SLV_RESP:
         begin
            if (slv_mx_rsp_ready)
               slv_state_nxt = SLV_IDLE;
         end
         default: slv_state_nxt = SLV_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         slv_state <= SLV_IDLE;
      else
         slv_state <= slv_state_nxt;
   end

   // --------------------------------------------------
   // Configuration bus strobes
   // --------------------------------------------------
   assign slv_cyc_go = (slv_state == SLV_CYC) && slv_mx_req_valid && !slv_did_req;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         slv_did_req <= 1'b0;
         tst_wr      <= '0;
         tst_rd      <= '0;
      end
      else
      begin
         if (slv_state == SLV_IDLE)
            slv_did_req <= 1'b0;
         else if (slv_cyc_go)
            slv_did_req <= 1'b1;
         for (int i = 0; i < NUM_TST; i++)
         begin
            tst_wr[i] <= slv_cyc_go && slv_cyc_wr && (slv_sel == tst_sel_t'(i));
            tst_rd[i] <= slv_cyc_go && !slv_cyc_wr && (slv_sel == tst_sel_t'(i));
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (slv_cyc_go)
      begin
         cfg_addr_q  <= slv_mx_addr;
         cfg_wdata_q <= axil_req.wdata;
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_TST; i++)
      begin
         cfg_req[i].addr  = cfg_addr_q;
         cfg_req[i].wdata = cfg_wdata_q;
         cfg_req[i].wr    = tst_wr[i];
         cfg_req[i].rd    = tst_rd[i];
      end
   end

   // Read data held through RESP
   always_ff @(posedge clk)
   begin
      if ((slv_state == SLV_CYC) && slv_cyc_done)
         slv_rdata <= sel_rdata;
   end

   // Pops of the request heads
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         aw_rdy_q <= 1'b0;
         w_rdy_q  <= 1'b0;
         ar_rdy_q <= 1'b0;
      end
      else
      begin
         aw_rdy_q <= (slv_state_nxt == SLV_WR_ADDR);
         w_rdy_q  <= (slv_state == SLV_CYC) && (slv_state_nxt == SLV_RESP) && slv_cyc_wr;
         ar_rdy_q <= (slv_state == SLV_CYC) && (slv_state_nxt == SLV_RESP) && !slv_cyc_wr;
      end
   end

   always_comb
   begin
      axil_rsp.awready = aw_rdy_q;
      axil_rsp.wready  = w_rdy_q;
      axil_rsp.arready = ar_rdy_q;
      axil_rsp.bvalid  = (slv_state == SLV_RESP) && slv_cyc_wr;
      axil_rsp.bresp   = '0;   // OKAY
      axil_rsp.rvalid  = (slv_state == SLV_RESP) && !slv_cyc_wr;
      axil_rsp.rdata   = slv_rdata;
      axil_rsp.rresp   = '0;
   end

endmodule

//--- hdl/ocl_cfg_top.sv
`timescale 1ns/1ps

module ocl_cfg_top #(
   parameter int NUM_TST    = 6,
   parameter int FIFO_DEPTH = 3,
   parameter int ACK_DLY    = 2
) (
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  ocl_cfg_pkg::axil_req_t host_req,
   output ocl_cfg_pkg::axil_rsp_t host_rsp
);

   import ocl_cfg_pkg::*;

   axil_req_t slv_req;             // FIFO heads toward the slave
   axil_rsp_t slv_rsp;
   cfg_req_t  cfg_req [NUM_TST];
   cfg_rsp_t  cfg_rsp [NUM_TST];

   // --------------------------------------------------
   // Host request FIFO
   // --------------------------------------------------
   axil_in_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_in_fifo (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .host_req   (host_req),
      .host_rsp   (host_rsp),
      .slv_req    (slv_req),
      .slv_rsp    (slv_rsp)
   );

   ocl_cfg_slv #(
      .NUM_TST (NUM_TST)
   ) u_slv (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .axil_req   (slv_req),
      .axil_rsp   (slv_rsp),
      .cfg_req    (cfg_req),
      .cfg_rsp    (cfg_rsp)
   );

   // One test block per implemented slot
   for (genvar g = 0; g < NUM_TST; g++)
   begin : g_tst
      tst_cfg_regs #(
         .ACK_DLY (ACK_DLY)
      ) u_tst (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .cfg_req    (cfg_req[g]),
         .cfg_rsp    (cfg_rsp[g])
      );
   end

endmodule

//--- test/tb_ocl_cfg_top.sv
`timescale 1ns/1ps

module tb_ocl_cfg_top;

   import ocl_cfg_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RST_CYCLES   = 8;
   localparam int NUM_TST      = 6;
   localparam int FIFO_DEPTH   = 3;
   localparam int ACK_DLY      = 2;
   localparam int SEED         = 19;
   localparam int BP_ACCESSES  = 12;
   localparam int WORST_CYC    = 40;                    // Per access with back-pressure
   localparam int N_ACCESS     = 24 + 2 + 48 + 10 + 2 + BP_ACCESSES;
   localparam int WATCHDOG_NS  = N_ACCESS * WORST_CYC * CLK_PERIOD + 2000;
   localparam int ACCEPT_LIMIT = WORST_CYC * (FIFO_DEPTH + 1);
   localparam int DRAIN_LIMIT  = WORST_CYC * 16;
   localparam axil_data_t UNMAPPED_WORD = 32'hdead_beef;

   logic       clk = 1'b0;
   logic       sync_rst_n = 1'b0;
   axil_req_t  drv_req = '0;       // Request channels from the driver tasks
   logic       b_rdy = 1'b1;
   logic       r_rdy = 1'b1;
   logic       bp_mode = 1'b0;     // Random bready/rready when set
   logic       chk_en = 1'b0;
   axil_req_t  host_req;
   axil_rsp_t  host_rsp;

   // Scoreboard state
   axil_addr_t aw_q [$];
   axil_data_t w_q [$];
   axil_addr_t ar_q [$];
   axil_data_t model [int];        // Key is slot * 4 + register
   logic       comp_log [$];       // 1 for B, 0 for R
   axil_data_t last_rdata = '0;
   int         err_cnt = 0;
   int         err_mark = 0;
   int         test_num = 0;
   int         n_pass = 0;
   int         n_fail = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   always_comb
   begin
      host_req        = drv_req;
      host_req.bready = b_rdy;
      host_req.rready = r_rdy;
   end

   ocl_cfg_top #(
      .NUM_TST    (NUM_TST),
      .FIFO_DEPTH (FIFO_DEPTH),
      .ACK_DLY    (ACK_DLY)
   ) uut (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .host_req   (host_req),
      .host_rsp   (host_rsp)
   );

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   function automatic axil_addr_t reg_addr(input int slot, input int r, input logic [7:0] junk);
      return {7'b0, 17'(slot), junk[7:4], 2'(r), junk[1:0]};   // Junk lands in unused bits
   endfunction

   function automatic logic is_mapped(input axil_addr_t a);
      return int'(a[24:8]) < NUM_TST;
   endfunction

   function automatic int reg_key(input axil_addr_t a);
      return int'(a[24:8]) * 4 + int'(a[3:2]);
   endfunction

   function automatic axil_data_t model_read(input axil_addr_t a);
      if (!is_mapped(a))
         return UNMAPPED_WORD;
      else if (model.exists(reg_key(a)))
         return model[reg_key(a)];
      else
         return '0;                                  // Registers reset to zero
   endfunction

   task automatic check_eq(input string name, input axil_data_t got, input axil_data_t exp);
      assert (got === exp)
      else
      begin
         $display("** Error at %t: %s expected %h, actual %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic report_fault(input string what);
      $display("Fault at %t: %s", $time, what);
      err_cnt++;
   endtask

   task automatic abort_run(input string why);
      $display("Run aborted at %t: %s", $time, why);
      $display("Simulation failed");
      $finish;
   endtask

   task automatic retire_write();
      axil_addr_t a;
      axil_data_t d;
      if (aw_q.size() == 0 || w_q.size() == 0)
         report_fault("write response without an outstanding write");
      else
      begin
         a = aw_q.pop_front();
         d = w_q.pop_front();
         check_eq("host_rsp.bresp", 32'(host_rsp.bresp), 32'h0);
         if (is_mapped(a))
            model[reg_key(a)] = d;                   // Unmapped writes are dropped
         comp_log.push_back(1'b1);
      end
   endtask

   task automatic retire_read();
      axil_addr_t a;
      if (ar_q.size() == 0)
         report_fault("read response without an outstanding read");
      else
      begin
         a = ar_q.pop_front();
         check_eq("host_rsp.rresp", 32'(host_rsp.rresp), 32'h0);
         check_eq("host_rsp.rdata", host_rsp.rdata, model_read(a));
         last_rdata = host_rsp.rdata;
         comp_log.push_back(1'b0);
      end
   endtask

   // Handshakes seen mid-cycle complete at the next rising edge
   always @(negedge clk)
   begin
      if (chk_en)
      begin
         assert (host_rsp.awready || aw_q.size() >= FIFO_DEPTH)
         else report_fault("awready low while the AW FIFO cannot be full");
         assert (host_rsp.wready || w_q.size() >= FIFO_DEPTH)
         else report_fault("wready low while the W FIFO cannot be full");
         assert (host_rsp.arready || ar_q.size() >= FIFO_DEPTH)
         else report_fault("arready low while the AR FIFO cannot be full");
      end
      if (host_req.awvalid && host_rsp.awready)
         aw_q.push_back(host_req.awaddr);
      if (host_req.wvalid && host_rsp.wready)
         w_q.push_back(host_req.wdata);
      if (host_req.arvalid && host_rsp.arready)
         ar_q.push_back(host_req.araddr);
      if (host_rsp.bvalid && host_req.bready)
         retire_write();
      if (host_rsp.rvalid && host_req.rready)
         retire_read();
   end

   // --------------------------------------------------
   // Protocol assertions
   // --------------------------------------------------
   rst_quiet: assert property (@(posedge clk) !sync_rst_n |=> !(host_rsp.bvalid ||
         host_rsp.rvalid || host_rsp.awready || host_rsp.wready || host_rsp.arready))
      else report_fault("valid or ready high after a reset cycle");

   b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
         (host_rsp.bvalid && !host_req.bready) |=> (host_rsp.bvalid && $stable(host_rsp.bresp)))
      else report_fault("bvalid or bresp changed before bready");

   r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
         (host_rsp.rvalid && !host_req.rready) |=>
         (host_rsp.rvalid && $stable(host_rsp.rdata) && $stable(host_rsp.rresp)))
      else report_fault("rvalid or rdata changed before rready");

   one_rsp: assert property (@(posedge clk) disable iff (!sync_rst_n)
         !(host_rsp.bvalid && host_rsp.rvalid))
      else report_fault("bvalid and rvalid high together");

   // bready and rready held high or randomly stalled
   always @(posedge clk)
   begin
      #1;
      b_rdy = bp_mode ? ($urandom_range(3) == 0) : 1'b1;
      r_rdy = bp_mode ? ($urandom_range(3) == 0) : 1'b1;
   end

   initial
   begin
      #(WATCHDOG_NS);
      abort_run($sformatf("watchdog expired after %0d ns", WATCHDOG_NS));
   end

   // --------------------------------------------------
   // Driver tasks run 1 ns after a rising edge
   // --------------------------------------------------
   task automatic send_req(input logic do_wr, input axil_addr_t wa, input axil_data_t wd,
                           input logic do_rd, input axil_addr_t ra);
      logic aw_ok;
      logic w_ok;
      logic ar_ok;
      int   n;
      drv_req.awaddr  = wa;
      drv_req.awvalid = do_wr;
      drv_req.wdata   = wd;
      drv_req.wstrb   = '1;
      drv_req.wvalid  = do_wr;
      drv_req.araddr  = ra;
      drv_req.arvalid = do_rd;
      n = 0;
      while ((drv_req.awvalid || drv_req.wvalid || drv_req.arvalid) && n < ACCEPT_LIMIT)
      begin
         @(negedge clk);
         aw_ok = drv_req.awvalid && host_rsp.awready;
         w_ok  = drv_req.wvalid && host_rsp.wready;
         ar_ok = drv_req.arvalid && host_rsp.arready;
         @(posedge clk);
         #1;
         if (aw_ok)
            drv_req.awvalid = 1'b0;
         if (w_ok)
            drv_req.wvalid = 1'b0;
         if (ar_ok)
            drv_req.arvalid = 1'b0;
         n++;
      end
      if (drv_req.awvalid || drv_req.wvalid || drv_req.arvalid)
      begin
         report_fault("host ready stayed low, request not accepted");
         drv_req.awvalid = 1'b0;
         drv_req.wvalid  = 1'b0;
         drv_req.arvalid = 1'b0;
      end
   endtask

   task automatic write_reg(input axil_addr_t a, input axil_data_t d);
      send_req(1'b1, a, d, 1'b0, '0);
   endtask

   task automatic read_reg(input axil_addr_t a);
      send_req(1'b0, '0, '0, 1'b1, a);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((aw_q.size() != 0 || w_q.size() != 0 || ar_q.size() != 0) && n < DRAIN_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (aw_q.size() != 0 || w_q.size() != 0 || ar_q.size() != 0)
         report_fault("responses did not arrive in time");
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (err_cnt == err_mark)
      begin
         n_pass++;
         $display("Test %0d (%s) passed", test_num, name);
      end
      else
      begin
         n_fail++;
         $display("Test %0d (%s) failed with %0d errors", test_num, name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------
   initial
   begin
      axil_addr_t a;
      int         mark;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(SEED));
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;
      @(negedge clk);
      check_eq("host_rsp.bvalid", 32'(host_rsp.bvalid), 32'h0);
      check_eq("host_rsp.rvalid", 32'(host_rsp.rvalid), 32'h0);
      check_eq("host_rsp.awready", 32'(host_rsp.awready), 32'h0);
      check_eq("host_rsp.wready", 32'(host_rsp.wready), 32'h0);
      check_eq("host_rsp.arready", 32'(host_rsp.arready), 32'h0);
      @(posedge clk);
      #1;
      chk_en = 1'b1;
      for (int s = 0; s < NUM_TST; s++)
         for (int r = 0; r < 4; r++)
            read_reg(reg_addr(s, r, 8'h00));
      wait_drain();
      end_test("reset");

      a = reg_addr(2, 1, 8'h00);
      write_reg(a, 32'h1234_5678);
      read_reg(a);
      wait_drain();
      check_eq("host_rsp.rdata", last_rdata, 32'h1234_5678);
      end_test("write then read");

      // Write through one alias and read back through random others
      for (int s = 0; s < NUM_TST; s++)
         for (int r = 0; r < 4; r++)
            write_reg(reg_addr(s, r, 8'hf3), {16'($urandom), 8'(s), 8'(r)});
      for (int s = 0; s < NUM_TST; s++)
         for (int r = 0; r < 4; r++)
            read_reg(reg_addr(s, r, 8'($urandom)));
      wait_drain();
      end_test("all registers");

      write_reg(reg_addr(NUM_TST, 0, 8'h00), 32'hffff_ffff);
      write_reg(32'h0100_0000, 32'h5555_aaaa);           // Slot 65536
      read_reg(reg_addr(NUM_TST, 0, 8'h00));
      read_reg(32'h0100_0000);
      for (int s = 0; s < NUM_TST; s++)
         read_reg(reg_addr(s, 0, 8'h00));
      wait_drain();
      end_test("unmapped slots");

      mark = comp_log.size();
      a = reg_addr(3, 2, 8'h00);
      send_req(1'b1, a, 32'hcafe_f00d, 1'b1, a);
      wait_drain();
      assert (comp_log.size() == mark + 2 && comp_log[mark] && !comp_log[mark + 1])
      else report_fault("write did not complete before the simultaneous read");
      check_eq("host_rsp.rdata", last_rdata, 32'hcafe_f00d);
      end_test("simultaneous AW W AR");

      bp_mode = 1'b1;
      for (int i = 0; i < BP_ACCESSES; i++)
      begin
         a = reg_addr($urandom_range(NUM_TST), $urandom_range(3), 8'($urandom));
         if (i % 3 == 2)
            read_reg(a);
         else
            write_reg(a, $urandom());
      end
      wait_drain();
      bp_mode = 1'b0;
      end_test("back-pressure");

      $display("Tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
      if (err_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- ocl_cfg.f
hdl/ocl_cfg_pkg.sv
hdl/axil_in_fifo.sv
hdl/tst_cfg_regs.sv
hdl/ocl_cfg_slv.sv
hdl/ocl_cfg_top.sv
test/tb_ocl_cfg_top.sv

//--- Makefile
SIM        = verilator
TOP        = tb_ocl_cfg_top
FILELIST   = ocl_cfg.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass line not found in $(LOG)"; exit 1)
	@echo "Simulation log check passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
